//--- build.f
design/mips_types_pkg.sv
design/mips_op_pkg.sv
design/exec_op_if.sv
design/int_alu.sv
design/mul_unit.sv
design/hilo_reg.sv
design/exec_ctrl.sv
design/exec_unit.sv
test/exec_unit_assertions.sv
test/tb_exec_unit.sv

//--- design/exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  mips_op_pkg::alu_op_e      aluop_i,
    input  mips_types_pkg::word_t     reg1_i,
    input  mips_types_pkg::word_t     reg2_i,
    input  mips_types_pkg::reg_addr_t wd_i,
    input  logic                      wreg_i,
    exec_op_if.ctrl                   op_bus,
    input  mips_types_pkg::word_t     alu_res_i,
    input  logic                      alu_ov_i,
    input  logic                      mul_done_i,
    input  mips_types_pkg::dword_t    mul_prod_i,
    input  mips_types_pkg::word_t     hi_i,
    input  mips_types_pkg::word_t     lo_i,
    output logic                      wb_valid_o,
    output mips_types_pkg::reg_addr_t wd_o,
    output logic                      wreg_o,
    output mips_types_pkg::word_t     wdata_o,
    output logic                      ov_o
);
    import mips_types_pkg::*;
    import mips_op_pkg::*;

    exec_state_e state_q;
    exec_state_e state_d;
    logic        accept;
    logic        new_is_mul;
    logic        cur_is_mul;
    reg_addr_t   wd_q;
    logic        wreg_q;
    res_sel_e    res_sel;
    word_t       res_word;
    logic        wb_fire;

    function automatic res_sel_e res_group(input alu_op_e op);
        case (op)
            OR, AND, NOR, XOR:                        return RES_LOGIC;
            SLL, SRL, SRA:                            return RES_SHIFT;
            ADD, ADDU, SUB, SUBU, SLT, SLTU, CLZ, CLO: return RES_ARITH;
            MFHI, MFLO:                               return RES_MOVE;
            MUL:                                      return RES_MUL;
            default:                                  return RES_NONE;  // mult, mt*, nop
        endcase
    endfunction

    // ready comes back in the done cycle so the next op lands on the hilo write edge
    assign issue_ready_o = (state_q == IDLE) || mul_done_i;
    assign accept        = issue_valid_i && issue_ready_o;
    assign new_is_mul    = aluop_i inside {MULT, MULTU, MUL};
    assign cur_is_mul    = op_bus.op inside {MULT, MULTU, MUL};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept && new_is_mul) begin
                    state_d = MUL_BUSY;
                end
            end
            MUL_BUSY: begin
                if (mul_done_i) begin
                    state_d = (accept && new_is_mul) ? MUL_BUSY : IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= IDLE;
            op_bus.op    <= NOP;
            op_bus.start <= 1'b0;
            wreg_q       <= 1'b0;
        end else begin
            state_q      <= state_d;
            op_bus.start <= accept;
            if (accept) begin
                op_bus.op <= aluop_i;
                wreg_q    <= wreg_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_bus.reg1 <= reg1_i;
            op_bus.reg2 <= reg2_i;
            wd_q        <= wd_i;
        end
    end

    assign res_sel = res_group(op_bus.op);

    always_comb begin
        case (res_sel)
            RES_LOGIC, RES_SHIFT, RES_ARITH: begin
                res_word = alu_res_i;
            end
            RES_MOVE: begin
                res_word = (op_bus.op == MFHI) ? hi_i : lo_i;
            end
            RES_MUL: begin
                res_word = mul_prod_i[31:0];  // low word only
            end
            default: begin
                res_word = '0;
            end
        endcase
    end

    // single-cycle ops retire one edge after start, multiplies on done
    assign wb_fire = (op_bus.start && (op_bus.op != NOP) && !cur_is_mul) || mul_done_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
            wd_o       <= '0;
            wreg_o     <= 1'b0;
            wdata_o    <= '0;
            ov_o       <= 1'b0;
        end else begin
            wb_valid_o <= wb_fire;
            wreg_o     <= wb_fire && wreg_q && !alu_ov_i;  // overflow kills the write
            ov_o       <= wb_fire && alu_ov_i;
            if (wb_fire) begin
                wd_o    <= wd_q;
                wdata_o <= res_word;
            end
        end
    end

endmodule

//--- design/exec_op_if.sv
`timescale 1ns/1ps

interface exec_op_if;
    import mips_types_pkg::*;
    import mips_op_pkg::*;

    alu_op_e op;     // op held for the units
    word_t   reg1;   // captured at acceptance
    word_t   reg2;
    logic    start;  // one cycle, op just taken

    // controller side
    modport ctrl (
        output op, reg1, reg2, start
    );

    modport alu (
        input op, reg1, reg2
    );

    modport mul (
        input op, reg1, reg2, start
    );

endinterface

//--- design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int MULT_STAGES = 3  // 2..4
) (
    input  logic                      clk,
    input  logic                      arst_n_i,
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  mips_op_pkg::alu_op_e      aluop_i,
    input  mips_types_pkg::word_t     reg1_i,
    input  mips_types_pkg::word_t     reg2_i,
    input  mips_types_pkg::reg_addr_t wd_i,
    input  logic                      wreg_i,
    output logic                      wb_valid_o,
    output mips_types_pkg::reg_addr_t wd_o,
    output logic                      wreg_o,
    output mips_types_pkg::word_t     wdata_o,
    output logic                      ov_o
);
    import mips_types_pkg::*;

    word_t  alu_res;
    logic   alu_ov;
    dword_t mul_prod;
    logic   mul_done;
    word_t  hi;
    word_t  lo;

    exec_op_if op_bus ();  // accepted op, shared by all units

    exec_ctrl u_exec_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .aluop_i       (aluop_i),
        .reg1_i        (reg1_i),
        .reg2_i        (reg2_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .op_bus        (op_bus),
        .alu_res_i     (alu_res),
        .alu_ov_i      (alu_ov),
        .mul_done_i    (mul_done),
        .mul_prod_i    (mul_prod),
        .hi_i          (hi),
        .lo_i          (lo),
        .wb_valid_o    (wb_valid_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .ov_o          (ov_o)
    );

    int_alu u_int_alu (
        .op_bus (op_bus),
        .res_o  (alu_res),
        .ov_o   (alu_ov)
    );

    mul_unit #(
        .MULT_STAGES (MULT_STAGES)
    ) u_mul_unit (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_bus   (op_bus),
        .prod_o   (mul_prod),
        .done_o   (mul_done)
    );

    hilo_reg u_hilo_reg (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .op_bus     (op_bus),
        .start_i    (op_bus.start),  // mt* write one edge after acceptance
        .mul_done_i (mul_done),
        .prod_i     (mul_prod),
        .hi_o       (hi),
        .lo_o       (lo)
    );

endmodule

//--- design/hilo_reg.sv
`timescale 1ns/1ps

module hilo_reg (
    input  logic                   clk,
    input  logic                   arst_n_i,
    exec_op_if.alu                 op_bus,
    input  logic                   start_i,
    input  logic                   mul_done_i,
    input  mips_types_pkg::dword_t prod_i,
    output mips_types_pkg::word_t  hi_o,
    output mips_types_pkg::word_t  lo_o
);
    import mips_op_pkg::*;

    logic prod_we;

    // mul only goes to the destination register
    assign prod_we = mul_done_i && (op_bus.op inside {MULT, MULTU});

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (prod_we) begin
            hi_o <= prod_i[63:32];
            lo_o <= prod_i[31:0];
        end else if (start_i && (op_bus.op == MTHI)) begin
            hi_o <= op_bus.reg1;  // lo untouched
        end else if (start_i && (op_bus.op == MTLO)) begin
            lo_o <= op_bus.reg1;  // hi untouched
        end
    end

endmodule

//--- design/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    exec_op_if.alu                op_bus,
    output mips_types_pkg::word_t res_o,
    output logic                  ov_o
);
    import mips_types_pkg::*;
    import mips_op_pkg::*;

    logic   is_sub;
    word_t  reg2_mux;
    word_t  sum;
    logic   ov_sum;
    logic   lt;
    shamt_t shamt;
    cnt_t   lead_cnt;

    // number of leading bits equal to b, 32 when the whole word matches
    function automatic cnt_t count_lead(input word_t w, input logic b);
        cnt_t n;
        logic hit;
        n   = cnt_t'(32);
        hit = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!hit && (w[i] != b)) begin
                n   = cnt_t'(31 - i);  // first differing bit from the top
                hit = 1'b1;
            end
        end
        return n;
    endfunction

    assign is_sub   = op_bus.op inside {SUB, SUBU, SLT};
    assign reg2_mux = is_sub ? (~op_bus.reg2 + 1'b1) : op_bus.reg2;  // two's complement
    assign sum      = op_bus.reg1 + reg2_mux;
    assign shamt    = op_bus.reg1[4:0];

    // signed overflow judged on the original operand signs
    always_comb begin
        if (is_sub) begin
            ov_sum = (op_bus.reg1[31] ^ op_bus.reg2[31]) & (sum[31] ^ op_bus.reg1[31]);
        end else begin
            ov_sum = ~(op_bus.reg1[31] ^ op_bus.reg2[31]) & (sum[31] ^ op_bus.reg1[31]);
        end
    end

    // slt looks at the difference sign, sltu is a plain compare
    always_comb begin
        if (op_bus.op == SLT) begin
            lt = (op_bus.reg1[31] && !op_bus.reg2[31]) ||
                 ((op_bus.reg1[31] == op_bus.reg2[31]) && sum[31]);
        end else begin
            lt = (op_bus.reg1 < op_bus.reg2);
        end
    end

    assign lead_cnt = count_lead(op_bus.reg1, op_bus.op == CLO);

    assign ov_o = (op_bus.op inside {ADD, SUB}) && ov_sum;  // addu/subu wrap silently

    always_comb begin
        case (op_bus.op)
            OR: begin
                res_o = op_bus.reg1 | op_bus.reg2;
            end
            AND: begin
                res_o = op_bus.reg1 & op_bus.reg2;
            end
            NOR: begin
                res_o = ~(op_bus.reg1 | op_bus.reg2);
            end
            XOR: begin
                res_o = op_bus.reg1 ^ op_bus.reg2;
            end
            SLL: begin
                res_o = op_bus.reg2 << shamt;
            end
            SRL: begin
                res_o = op_bus.reg2 >> shamt;
            end
            SRA: begin
                res_o = word_t'($signed(op_bus.reg2) >>> shamt);  // sign fill
            end
            ADD, ADDU, SUB, SUBU: begin
                res_o = sum;
            end
            SLT, SLTU: begin
                res_o = word_t'(lt);
            end
            CLZ, CLO: begin
                res_o = word_t'(lead_cnt);
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

//--- design/mips_op_pkg.sv
package mips_op_pkg;

    // operation codes, same values as the pipeline decoder
    typedef enum logic [7:0] {
        NOP   = 8'b0000_0000,
        OR    = 8'b0010_0101,
        AND   = 8'b0010_0100,
        NOR   = 8'b0010_0111,
        XOR   = 8'b0010_0110,
        SLL   = 8'b0111_1100,
        SRL   = 8'b0000_0010,
        SRA   = 8'b0000_0011,
        ADD   = 8'b0010_0000,
        ADDU  = 8'b0010_0001,
        SUB   = 8'b0010_0010,
        SUBU  = 8'b0010_0011,
        SLT   = 8'b0010_1010,
        SLTU  = 8'b0010_1011,
        CLZ   = 8'b1011_0000,
        CLO   = 8'b1011_0001,
        MFHI  = 8'b0001_0000,
        MFLO  = 8'b0001_0010,
        MTHI  = 8'b0001_0001,
        MTLO  = 8'b0001_0011,
        MULT  = 8'b0001_1000,
        MULTU = 8'b0001_1001,
        MUL   = 8'b1010_1001
    } alu_op_e;

    // result groups for the write-back mux
    typedef enum logic [2:0] {
        RES_NONE  = 3'b000,
        RES_LOGIC = 3'b001,
        RES_SHIFT = 3'b010,
        RES_MOVE  = 3'b011,
        RES_ARITH = 3'b100,
        RES_MUL   = 3'b101
    } res_sel_e;

    typedef enum logic {
        IDLE,
        MUL_BUSY
    } exec_state_e;

endpackage

//--- design/mips_types_pkg.sv
package mips_types_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int CNT_W      = 6;  // must hold 0..32

    typedef logic [WORD_W-1:0]     word_t;   // operand, result, hi, lo
    typedef logic [2*WORD_W-1:0]   dword_t;  // {hi, lo}
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;  // low bits of reg1
    typedef logic [CNT_W-1:0]      cnt_t;    // clz / clo result

endpackage

//--- design/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
    parameter int MULT_STAGES = 3
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    exec_op_if.mul                 op_bus,
    output mips_types_pkg::dword_t prod_o,
    output logic                   done_o
);
    import mips_types_pkg::*;
    import mips_op_pkg::*;

    localparam int CNT_W = $clog2(MULT_STAGES);

    logic             mul_req;
    logic             is_signed;
    word_t            mag1;
    word_t            mag2;
    dword_t           prod_q;
    logic             neg_q;
    logic             busy_q;
    logic [CNT_W-1:0] cnt_q;

    assign mul_req   = op_bus.start && (op_bus.op inside {MULT, MULTU, MUL});
    assign is_signed = (op_bus.op == MULT) || (op_bus.op == MUL);

    // magnitudes for the signed forms
    assign mag1 = (is_signed && op_bus.reg1[31]) ? (~op_bus.reg1 + 1'b1) : op_bus.reg1;
    assign mag2 = (is_signed && op_bus.reg2[31]) ? (~op_bus.reg2 + 1'b1) : op_bus.reg2;

    always_ff @(posedge clk) begin
        if (mul_req) begin
            prod_q <= mag1 * mag2;
            neg_q  <= is_signed && (op_bus.reg1[31] ^ op_bus.reg2[31]);  // signs differ
        end
    end

    // first stage is the product register, the counter covers the rest
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (mul_req) begin
            busy_q <= 1'b1;
            cnt_q  <= CNT_W'(MULT_STAGES - 2);
        end else if (busy_q) begin
            if (cnt_q == '0) begin
                busy_q <= 1'b0;  // done seen this cycle
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign done_o = busy_q && (cnt_q == '0);
    assign prod_o = neg_q ? (~prod_q + 1'b1) : prod_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exec_unit -f build.f \
    --Mdir obj_dir -o sim_exec_unit

./obj_dir/sim_exec_unit | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- test/exec_unit_assertions.sv
`timescale 1ns/1ps

module exec_unit_assertions #(
    parameter int MULT_STAGES = 3
) (
    input logic                  clk,
    input logic                  arst_n_i,
    input logic                  issue_valid_i,
    input logic                  issue_ready_i,
    input mips_op_pkg::alu_op_e  aluop_i,
    input logic                  wb_valid_i,
    input logic                  wb_wreg_i,
    input logic                  wb_ov_i,
    input mips_types_pkg::word_t wb_data_i
);
    import mips_op_pkg::*;

    logic mul_taken;
    int   low_left;  // ready-low cycles still owed

    assign mul_taken = issue_valid_i && issue_ready_i && (aluop_i inside {MULT, MULTU, MUL});

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            low_left <= 0;
        end else if (mul_taken) begin
            low_left <= MULT_STAGES - 1;
        end else if (low_left > 0) begin
            low_left <= low_left - 1;
        end
    end

    ov_kills_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ov_i |-> !wb_wreg_i) else $error("overflow with register write");

    wb_single_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_valid_i && !issue_ready_i |=> !wb_valid_i) else $error("write-back longer than a pulse");

    ready_low_in_mul: assert property (@(posedge clk) disable iff (!arst_n_i)
        low_left > 0 |-> !issue_ready_i) else $error("ready high during multiply");

    ready_back_after_mul: assert property (@(posedge clk) disable iff (!arst_n_i)
        low_left == 1 |=> issue_ready_i) else $error("ready late after multiply");

    idle_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !wb_valid_i && !wb_wreg_i && !wb_ov_i && wb_data_i == '0 && issue_ready_i)
        else $error("outputs active during reset");

endmodule

//--- test/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
    import mips_types_pkg::*;
    import mips_op_pkg::*;

    localparam int MULT_STAGES = 3;
    localparam int N_TBL       = 40;
    localparam int N_RAND      = 48;
    localparam int TIMEOUT     = (N_TBL + N_RAND) * (MULT_STAGES + 2) + 100;

    typedef struct packed {
        alu_op_e   op;
        word_t     r1;
        word_t     r2;
        reg_addr_t wd;
        logic      wreg;
        word_t     data;      // checked only when a write is expected
        logic      exp_wreg;
        logic      exp_ov;
    } stim_t;

    typedef struct packed {
        reg_addr_t wd;
        word_t     data;
        logic      wreg;
        logic      ov;
    } wb_exp_t;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        issue_valid_i;
    logic        issue_ready_o;
    alu_op_e     aluop_i;
    word_t       reg1_i;
    word_t       reg2_i;
    reg_addr_t   wd_i;
    logic        wreg_i;
    logic        wb_valid_o;
    reg_addr_t   wd_o;
    logic        wreg_o;
    word_t       wdata_o;
    logic        ov_o;

    stim_t       tbl [N_TBL];
    wb_exp_t     exp_q [$];   // write-backs still owed, in issue order
    wb_exp_t     got;
    logic        prev_mul = 1'b0;
    int          errors = 0;
    int          checks = 0;
    int          cycles;
    logic [31:0] rng = 32'd66699;
    alu_op_e     rand_ops [13] = '{OR, AND, NOR, XOR, SLL, SRL, SRA,
                                   ADD, ADDU, SUB, SUBU, SLT, SLTU};

    always #5 clk = ~clk;

    exec_unit #(
        .MULT_STAGES (MULT_STAGES)
    ) u_exec_unit (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_o (issue_ready_o),
        .aluop_i       (aluop_i),
        .reg1_i        (reg1_i),
        .reg2_i        (reg2_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .wb_valid_o    (wb_valid_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o),
        .ov_o          (ov_o)
    );

    bind exec_unit exec_unit_assertions #(
        .MULT_STAGES (MULT_STAGES)
    ) u_exec_unit_assertions (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_ready_i (issue_ready_o),
        .aluop_i       (aluop_i),
        .wb_valid_i    (wb_valid_o),
        .wb_wreg_i     (wreg_o),
        .wb_ov_i       (ov_o),
        .wb_data_i     (wdata_o)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected result of the single-cycle ops used by the random section
    function automatic word_t alu_result(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            OR:        return a | b;
            AND:       return a & b;
            NOR:       return ~(a | b);
            XOR:       return a ^ b;
            SLL:       return b << a[4:0];
            SRL:       return b >> a[4:0];
            SRA:       return word_t'($signed(b) >>> a[4:0]);
            ADD, ADDU: return a + b;
            SUB, SUBU: return a - b;
            SLT:       return word_t'($signed(a) < $signed(b));
            SLTU:      return word_t'(a < b);
            default:   return '0;
        endcase
    endfunction

    // true result outside the signed 32-bit range
    function automatic logic signed_overflow(input alu_op_e op, input word_t a, input word_t b);
        longint s;
        if (op == ADD) begin
            s = longint'($signed(a)) + longint'($signed(b));
        end else if (op == SUB) begin
            s = longint'($signed(a)) - longint'($signed(b));
        end else begin
            return 1'b0;
        end
        return (s > 64'sd2147483647) || (s < -64'sd2147483648);
    endfunction

    task automatic load_table();
        tbl[0]  = '{OR,    32'hF0F0_0000, 32'h0000_0F0F, 5'd1,  1'b1, 32'hF0F0_0F0F, 1'b1, 1'b0};
        tbl[1]  = '{AND,   32'hFF00_FF00, 32'h0F0F_0F0F, 5'd2,  1'b1, 32'h0F00_0F00, 1'b1, 1'b0};
        tbl[2]  = '{NOR,   32'h0000_FFFF, 32'h00FF_0000, 5'd3,  1'b1, 32'hFF00_0000, 1'b1, 1'b0};
        tbl[3]  = '{XOR,   32'hAAAA_AAAA, 32'hFFFF_0000, 5'd4,  1'b1, 32'h5555_AAAA, 1'b1, 1'b0};
        tbl[4]  = '{SLL,   32'h0000_0024, 32'h0000_00F1, 5'd5,  1'b1, 32'h0000_0F10, 1'b1, 1'b0};
        tbl[5]  = '{SRL,   32'h0000_0008, 32'h8000_0000, 5'd6,  1'b1, 32'h0080_0000, 1'b1, 1'b0};
        tbl[6]  = '{SRA,   32'h0000_0008, 32'h8000_0000, 5'd7,  1'b1, 32'hFF80_0000, 1'b1, 1'b0};
        tbl[7]  = '{SRA,   32'hFFFF_FFFF, 32'h4000_0000, 5'd8,  1'b1, 32'h0000_0000, 1'b1, 1'b0};
        tbl[8]  = '{ADDU,  32'hFFFF_FFFF, 32'h0000_0002, 5'd9,  1'b1, 32'h0000_0001, 1'b1, 1'b0};
        tbl[9]  = '{SUBU,  32'h0000_0000, 32'h0000_0001, 5'd10, 1'b1, 32'hFFFF_FFFF, 1'b1, 1'b0};
        tbl[10] = '{ADD,   32'h7FFF_FFFF, 32'h0000_0001, 5'd11, 1'b1, 32'h8000_0000, 1'b0, 1'b1};
        tbl[11] = '{SUB,   32'h8000_0000, 32'h0000_0001, 5'd12, 1'b1, 32'h7FFF_FFFF, 1'b0, 1'b1};
        tbl[12] = '{ADD,   32'h0000_0005, 32'hFFFF_FFFD, 5'd13, 1'b1, 32'h0000_0002, 1'b1, 1'b0};
        tbl[13] = '{ADDU,  32'h7FFF_FFFF, 32'h0000_0001, 5'd14, 1'b1, 32'h8000_0000, 1'b1, 1'b0};
        tbl[14] = '{SLT,   32'hFFFF_FFFF, 32'h0000_0001, 5'd15, 1'b1, 32'h0000_0001, 1'b1, 1'b0};
        tbl[15] = '{SLTU,  32'hFFFF_FFFF, 32'h0000_0001, 5'd16, 1'b1, 32'h0000_0000, 1'b1, 1'b0};
        tbl[16] = '{SLT,   32'h7FFF_FFFF, 32'h8000_0000, 5'd17, 1'b1, 32'h0000_0000, 1'b1, 1'b0};
        tbl[17] = '{CLZ,   32'h0000_0000, 32'h0000_0000, 5'd18, 1'b1, 32'h0000_0020, 1'b1, 1'b0};
        tbl[18] = '{CLO,   32'hFFFF_FFFF, 32'h0000_0000, 5'd19, 1'b1, 32'h0000_0020, 1'b1, 1'b0};
        tbl[19] = '{CLZ,   32'h0001_0000, 32'h0000_0000, 5'd20, 1'b1, 32'h0000_000F, 1'b1, 1'b0};
        tbl[20] = '{CLO,   32'hF000_0000, 32'h0000_0000, 5'd21, 1'b1, 32'h0000_0004, 1'b1, 1'b0};
        tbl[21] = '{CLZ,   32'h8000_0000, 32'h0000_0000, 5'd22, 1'b1, 32'h0000_0000, 1'b1, 1'b0};
        tbl[22] = '{MULT,  32'h8000_0000, 32'h8000_0000, 5'd23, 1'b0, 32'h0000_0000, 1'b0, 1'b0};
        tbl[23] = '{MFHI,  32'h0000_0000, 32'h0000_0000, 5'd24, 1'b1, 32'h4000_0000, 1'b1, 1'b0};
        tbl[24] = '{MFLO,  32'h0000_0000, 32'h0000_0000, 5'd25, 1'b1, 32'h0000_0000, 1'b1, 1'b0};
        tbl[25] = '{MULT,  32'h7FFF_FFFF, 32'h8000_0000, 5'd26, 1'b0, 32'h0000_0000, 1'b0, 1'b0};
        tbl[26] = '{MFHI,  32'h0000_0000, 32'h0000_0000, 5'd27, 1'b1, 32'hC000_0000, 1'b1, 1'b0};
        tbl[27] = '{MFLO,  32'h0000_0000, 32'h0000_0000, 5'd28, 1'b1, 32'h8000_0000, 1'b1, 1'b0};
        tbl[28] = '{MULTU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd29, 1'b0, 32'h0000_0000, 1'b0, 1'b0};
        tbl[29] = '{MFHI,  32'h0000_0000, 32'h0000_0000, 5'd30, 1'b1, 32'hFFFF_FFFE, 1'b1, 1'b0};
        tbl[30] = '{MUL,   32'hFFFF_FFFF, 32'h0000_0007, 5'd31, 1'b1, 32'hFFFF_FFF9, 1'b1, 1'b0};
        tbl[31] = '{MFLO,  32'h0000_0000, 32'h0000_0000, 5'd0,  1'b1, 32'h0000_0001, 1'b1, 1'b0};
        tbl[32] = '{MFHI,  32'h0000_0000, 32'h0000_0000, 5'd1,  1'b1, 32'hFFFF_FFFE, 1'b1, 1'b0};
        tbl[33] = '{MTHI,  32'h1234_5678, 32'h0000_0000, 5'd2,  1'b0, 32'h0000_0000, 1'b0, 1'b0};
        tbl[34] = '{MFHI,  32'h0000_0000, 32'h0000_0000, 5'd3,  1'b1, 32'h1234_5678, 1'b1, 1'b0};
        tbl[35] = '{MFLO,  32'h0000_0000, 32'h0000_0000, 5'd4,  1'b1, 32'h0000_0001, 1'b1, 1'b0};
        tbl[36] = '{MTLO,  32'h1357_9BDF, 32'h0000_0000, 5'd5,  1'b0, 32'h0000_0000, 1'b0, 1'b0};
        tbl[37] = '{MFLO,  32'h0000_0000, 32'h0000_0000, 5'd6,  1'b1, 32'h1357_9BDF, 1'b1, 1'b0};
        tbl[38] = '{MFHI,  32'h0000_0000, 32'h0000_0000, 5'd7,  1'b1, 32'h1234_5678, 1'b1, 1'b0};
        tbl[39] = '{NOP,   32'h0000_0000, 32'h0000_0000, 5'd8,  1'b0, 32'h0000_0000, 1'b0, 1'b0};
    endtask

    // called right after a rising edge, returns at the accepting edge
    task automatic issue_op(input alu_op_e op, input word_t r1, input word_t r2,
                            input reg_addr_t wd, input logic wreg, input word_t exp_data,
                            input logic exp_wreg, input logic exp_ov);
        int stalls;
        int want;
        stalls        = 0;
        want          = prev_mul ? MULT_STAGES - 1 : 0;
        issue_valid_i <= 1'b1;
        aluop_i       <= op;
        reg1_i        <= r1;
        reg2_i        <= r2;
        wd_i          <= wd;
        wreg_i        <= wreg;
        @(negedge clk);
        while (!issue_ready_o) begin
            stalls++;  // valid held high, no acceptance yet
            @(negedge clk);
        end
        checks++;
        assert (stalls == want) else begin
            errors++;
            $display("[ERROR] %0t: %s accepted after %0d stall cycles, expected %0d",
                     $time, op.name(), stalls, want);
        end
        @(posedge clk);
        if (op != NOP) begin
            exp_q.push_back(wb_exp_t'{wd, exp_data, exp_wreg, exp_ov});
        end
        prev_mul = op inside {MULT, MULTU, MUL};
    endtask

    // write-back outputs are compared mid-cycle
    always @(negedge clk) begin
        if (arst_n_i && wb_valid_o) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("write-back pulse at %0t with no operation outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                got = exp_q.pop_front();
                checks++;
                assert (wd_o == got.wd && wreg_o == got.wreg && ov_o == got.ov &&
                        (!got.wreg || wdata_o == got.data)) else begin
                    errors++;
                    $display("[ERROR] %0t: wb wd=%0d wreg=%b ov=%b data=%h, expected %0d %b %b %h",
                             $time, wd_o, wreg_o, ov_o, wdata_o,
                             got.wd, got.wreg, got.ov, got.data);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        word_t   a;
        word_t   b;
        alu_op_e op;
        logic    ov;
        int      drain;
        arst_n_i      = 1'b0;
        issue_valid_i = 1'b0;
        aluop_i       = NOP;
        reg1_i        = '0;
        reg2_i        = '0;
        wd_i          = '0;
        wreg_i        = 1'b0;
        load_table();
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < N_TBL; i++) begin
            issue_op(tbl[i].op, tbl[i].r1, tbl[i].r2, tbl[i].wd, tbl[i].wreg,
                     tbl[i].data, tbl[i].exp_wreg, tbl[i].exp_ov);
        end
        for (int k = 0; k < N_RAND; k++) begin
            rng = xorshift(rng);
            op  = rand_ops[rng % 13];
            rng = xorshift(rng);
            a   = rng;
            rng = xorshift(rng);
            b   = rng;
            ov  = signed_overflow(op, a, b);
            issue_op(op, a, b, reg_addr_t'(k), 1'b1, alu_result(op, a, b), !ov, ov);
        end
        issue_valid_i <= 1'b0;
        drain = 0;
        while (exp_q.size() != 0 && drain < MULT_STAGES + 4) begin
            @(negedge clk);
            drain++;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d write-back pulses never arrived", exp_q.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
